// File: project.f
+incdir+include
design/FetchTypes.sv
design/FetchAxiReader.sv
design/FetchPcStage.sv
design/InsnTraverseStage.sv
design/InsnBuffer.sv
design/InsnAligner.sv
design/FetchUnit.sv
verif/FetchClockGen.sv
verif/FetchUnit_assertions.sv
verif/FetchUnitTb.sv

// File: Makefile
SIM       = verilator
TOP       = FetchUnitTb
FILELIST  = project.f
BUILD_DIR = obj_dir
SIM_FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/FetchUnitTb.sv
// Fetch unit testbench
`timescale 1ns/1ps
`include "fetch_defs.svh"

module FetchUnitTb import FetchTypes::*; ();
    localparam int NUM_TESTS = 6;
    localparam int MEM_WORDS = 512;                     // 2 KB, address bits 10:2
    localparam int LINE_BYTES = `FETCH_LINE_WIDTH / 8;
    localparam int WORD_BYTES = `FETCH_AXI_DATA_WIDTH / 8;
    localparam int CYCLES_PER_INSN = 40;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        vaddr_t     startPc;
        logic [1:0] pattern;    // 0 all 32-bit, 1 all 16-bit, 2 mixed
        int         count;
        logic       bpMode;     // random insnReady
        int         redirAt;    // -1 means no mid-test redirect
        vaddr_t     redirPc;
        vaddr_t     faultLo;    // SLVERR window, lo inclusive
        vaddr_t     faultHi;
    } testCase_t;

    testCase_t tests [NUM_TESTS] = '{
        '{32'h0000_0100, 2'd0, 24, 1'b0, -1, 32'h0, 32'h0, 32'h0},
        '{32'h0000_0200, 2'd1, 32, 1'b0, -1, 32'h0, 32'h0, 32'h0},
        '{32'h0000_0300, 2'd2, 40, 1'b0, -1, 32'h0, 32'h0, 32'h0},
        '{32'h0000_040a, 2'd2, 30, 1'b0, -1, 32'h0, 32'h0, 32'h0},   // upper half entry
        '{32'h0000_0500, 2'd2, 30, 1'b0, 12, 32'h0000_05a6, 32'h0, 32'h0},
        '{32'h0000_0600, 2'd2, 40, 1'b1, -1, 32'h0, 32'h0000_0620, 32'h0000_0640}
    };

    logic clk;
    logic rst;
    logic arValid;
    logic arReady;
    axiAr_t ar;
    logic rValid;
    logic rReady;
    axiR_t r;
    logic redirectValid;
    vaddr_t redirectPc;
    logic insnValid;
    fetchedInsn_t insn;
    logic insnReady;

    logic [31:0] mem [MEM_WORDS];
    vaddr_t faultLo;
    vaddr_t faultHi;
    fetchedInsn_t expQ [$];
    int errorCount;
    int testsPassed;
    int testsFailed;

    FetchClockGen #(.PERIOD(100), .RESET_CYCLES(RESET_CYCLES)) u_clk (.clk, .rst);

    FetchUnit u_dut (
        .clk, .rst, .arValid, .arReady, .ar, .rValid, .rReady, .r,
        .redirectValid, .redirectPc, .insnValid, .insn, .insnReady
    );

    function automatic int memIndex(input vaddr_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic logic inWindow(input vaddr_t addr);
        return (addr >= faultLo) && (addr < faultHi);
    endfunction

    // both beats of a line share one fault bit
    function automatic logic lineFaultAt(input vaddr_t addr);
        vaddr_t base;
        base = addr - (addr % LINE_BYTES);
        return inWindow(base) || inWindow(base + 4);
    endfunction

    function automatic logic [31:0] mixAddr(input vaddr_t addr, input logic [31:0] salt);
        logic [31:0] x;
        x = (addr ^ salt) * 32'h9e37_79b1;
        x = x ^ (x >> 15);
        x = x * 32'h85eb_ca77;
        return x ^ (x >> 13);
    endfunction

    // low bits 11 marks a 32-bit start
    function automatic parcel_t parcelFor(input vaddr_t addr, input logic [1:0] pattern,
                                          input logic [31:0] salt);
        logic [31:0] h;
        h = mixAddr(addr, salt);
        case (pattern)
            2'd0: return {h[15:2], 2'b11};
            2'd1: return {h[15:2], 1'b0, h[0]};
            default: return h[16] ? {h[15:2], 2'b11} : {h[15:2], h[1], 1'b0};
        endcase
    endfunction

    function automatic parcel_t parcelAt(input vaddr_t addr);
        logic [31:0] w;
        w = mem[memIndex(addr)];
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    task automatic fillMemory(input logic [1:0] pattern, input logic [31:0] salt);
        vaddr_t a;
        for (int w = 0; w < MEM_WORDS; w++) begin
            a = vaddr_t'(w) << 2;
            mem[w] = {parcelFor(a + 2, pattern, salt), parcelFor(a, pattern, salt)};
        end
    endtask

    // reference walker over memory, appends n instructions
    task automatic walkProgram(input vaddr_t start, input int n);
        vaddr_t pc;
        parcel_t lo;
        fetchedInsn_t e;
        pc = start;
        for (int k = 0; k < n; k++) begin
            lo = parcelAt(pc);
            e.pc = pc;
            e.fault = lineFaultAt(pc);
            if (lo[1:0] == 2'b11) begin
                e.insn = {parcelAt(pc + 2), lo};
                e.isCompressed = 1'b0;
                e.fault = e.fault | lineFaultAt(pc + 2);
                pc = pc + 4;
            end else begin
                e.insn = {16'h0000, lo};
                e.isCompressed = 1'b1;
                pc = pc + 2;
            end
            expQ.push_back(e);
        end
    endtask

    task automatic checkInsn(input fetchedInsn_t got, input fetchedInsn_t exp);
        if (got.pc !== exp.pc) begin
            $display("error: insn.pc got %h expected %h", got.pc, exp.pc);
            errorCount++;
        end
        if (got.insn !== exp.insn) begin
            $display("error: insn.insn got %h expected %h (pc %h)", got.insn, exp.insn, exp.pc);
            errorCount++;
        end
        if (got.isCompressed !== exp.isCompressed) begin
            $display("error: insn.isCompressed got %h expected %h (pc %h)",
                     got.isCompressed, exp.isCompressed, exp.pc);
            errorCount++;
        end
        if (got.fault !== exp.fault) begin
            $display("error: insn.fault got %h expected %h (pc %h)", got.fault, exp.fault, exp.pc);
            errorCount++;
        end
    endtask

    task automatic checkAr(input axiAr_t got, input axiAr_t exp);
        if (got.addr !== exp.addr) begin
            $display("error: ar.addr got %h expected %h", got.addr, exp.addr);
            errorCount++;
        end
        if (got.prot[2] !== exp.prot[2]) begin      // instruction bit, the rest is free
            $display("error: ar.prot[2] got %h expected %h", got.prot[2], exp.prot[2]);
            errorCount++;
        end
    endtask

    task automatic runTest(input int idx);
        testCase_t tc;
        int seen;
        int errsBefore;
        logic startPending;
        logic redirDone;
        tc = tests[idx];
        errsBefore = errorCount;
        faultLo = tc.faultLo;
        faultHi = tc.faultHi;
        fillMemory(tc.pattern, 32'(idx) * 32'h0101_7c3d);
        expQ.delete();
        if (tc.redirAt >= 0) begin
            walkProgram(tc.startPc, tc.redirAt);
            walkProgram(tc.redirPc, tc.count - tc.redirAt);
        end else begin
            walkProgram(tc.startPc, tc.count);
        end
        seen = 0;
        startPending = 1'b1;
        redirDone = 1'b0;
        while (seen < tc.count) begin
            @(posedge clk);
            #1;
            redirectValid = 1'b0;
            insnReady = tc.bpMode ? ($urandom_range(0, 1) == 1) : 1'b1;
            if (startPending) begin
                redirectValid = 1'b1;          // no handshake in a redirect cycle
                redirectPc = tc.startPc;
                insnReady = 1'b0;
                startPending = 1'b0;
            end else if (!redirDone && seen == tc.redirAt) begin
                redirectValid = 1'b1;
                redirectPc = tc.redirPc;
                insnReady = 1'b0;
                redirDone = 1'b1;
            end
            @(negedge clk);
            if (insnValid && insnReady) begin
                checkInsn(insn, expQ[seen]);
                seen++;
            end
        end
        @(posedge clk);
        #1;
        insnReady = 1'b0;
        redirectValid = 1'b0;
        if (errorCount == errsBefore)
            testsPassed++;
        else
            testsFailed++;
        $display("test %0d start %h: %0d instructions, %0d mismatches", idx, tc.startPc,
                 seen, errorCount - errsBefore);
    endtask

    // AXI4-Lite read slave, one outstanding read
    initial begin : axiMemory
        logic arFire;
        logic rFire;
        logic pending;
        logic secondBeat;       // next AR is the upper word of the line
        vaddr_t pendAddr;
        vaddr_t lineBase;
        axiAr_t arSeen;
        axiAr_t expAr;
        int delay;
        arReady = 1'b0;
        rValid = 1'b0;
        r = '0;
        pending = 1'b0;
        secondBeat = 1'b0;
        pendAddr = '0;
        lineBase = '0;
        arSeen = '0;
        expAr = '0;
        delay = 0;
        forever begin
            @(negedge clk);
            arFire = arValid && arReady && !rst;
            rFire = rValid && rReady;
            arSeen = ar;
            @(posedge clk);
            #1;
            if (rst) begin
                rValid = 1'b0;
                arReady = 1'b0;
                pending = 1'b0;
                secondBeat = 1'b0;
            end else begin
                if (rFire)
                    rValid = 1'b0;
                if (arFire) begin
                    // low word of the line first, then the word after it
                    if (!secondBeat)
                        lineBase = arSeen.addr - (arSeen.addr % LINE_BYTES);
                    expAr.addr = secondBeat ? lineBase + WORD_BYTES : lineBase;
                    expAr.prot = 3'b100;               // instruction access
                    checkAr(arSeen, expAr);
                    secondBeat = !secondBeat;
                    pending = 1'b1;
                    pendAddr = arSeen.addr;
                    delay = $urandom_range(0, 3);      // AR to R gap
                end
                if (pending && !rValid) begin
                    if (delay == 0) begin
                        rValid = 1'b1;
                        r.data = mem[memIndex(pendAddr)];
                        r.resp = inWindow(pendAddr) ? 2'b10 : 2'b00;   // SLVERR
                        pending = 1'b0;
                    end else begin
                        delay--;
                    end
                end
                arReady = ($urandom_range(0, 3) != 0);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = RESET_CYCLES;
        for (int i = 0; i < NUM_TESTS; i++)
            limit += tests[i].count * CYCLES_PER_INSN;
        repeat (limit) @(posedge clk);
        $display("timeout: the instruction stream stopped before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6bbc_06ae));
        redirectValid = 1'b0;
        redirectPc = '0;
        insnReady = 1'b0;
        faultLo = '0;
        faultHi = '0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        @(negedge rst);
        for (int i = 0; i < NUM_TESTS; i++)
            runTest(i);
        $display("tests passed %0d failed %0d", testsPassed, testsFailed);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// File: verif/FetchUnit_assertions.sv
// Fetch unit protocol checks
`timescale 1ns/1ps
`include "fetch_defs.svh"

module FetchUnitAssertions import FetchTypes::*; (
    input logic                              clk,
    input logic                              rst,
    input logic                              arValid,
    input logic                              arReady,
    input axiAr_t                            ar,
    input logic                              insnValid,
    input fetchedInsn_t                      insn,
    input logic                              insnReady,
    input logic                              redirectValid,
    input logic                              writeLow,
    input logic                              writeHigh,
    input logic [`INSN_BUFFER_CNT_WIDTH-1:0] writableCount
);
    // AR held until accepted
    arHoldCheck: assert property (@(posedge clk) disable iff (rst)
        arValid && !arReady |=> arValid && $stable(ar))
        else $error("AR request dropped or changed before arReady");

    // a redirect may legally kill the head instruction
    insnHoldCheck: assert property (@(posedge clk) disable iff (rst)
        insnValid && !insnReady && !redirectValid |=> insnValid && $stable(insn))
        else $error("instruction dropped or changed before insnReady");

    writeRoomCheck: assert property (@(posedge clk) disable iff (rst)
        (32'(writeLow) + 32'(writeHigh)) <= 32'(writableCount))
        else $error("buffer written beyond its free entries");

    resetQuietCheck: assert property (@(posedge clk) rst |=> !insnValid)
        else $error("instruction valid right after reset");
endmodule

bind FetchUnit FetchUnitAssertions u_assert (
    .clk, .rst, .arValid, .arReady, .ar, .insnValid, .insn, .insnReady,
    .redirectValid, .writeLow, .writeHigh, .writableCount
);

// File: verif/FetchClockGen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module FetchClockGen #(
    parameter int PERIOD = 100,         // ns
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released just after an edge, like every other driven input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end
endmodule

// File: design/FetchUnit.sv
// Instruction fetch front end
`timescale 1ns/1ps
`include "fetch_defs.svh"

module FetchUnit import FetchTypes::*; (
    input  logic         clk,
    input  logic         rst,
    output logic         arValid,
    input  logic         arReady,
    output axiAr_t       ar,
    input  logic         rValid,
    output logic         rReady,
    input  axiR_t        r,
    input  logic         redirectValid,
    input  vaddr_t       redirectPc,
    output logic         insnValid,
    output fetchedInsn_t insn,
    input  logic         insnReady
);
    // PC stage and reader
    logic lineReq;
    vaddr_t lineAddr;
    logic busy;
    logic lineDone;
    lineResp_t lineResp;

    // PC stage and traverse
    logic lineValid;
    lineResp_t lineOut;
    logic stall;
    logic flush;

    // traverse, buffer and aligner
    logic writeLow;
    logic writeHigh;
    insnEntry_t entryLow;
    insnEntry_t entryHigh;
    logic [`INSN_BUFFER_CNT_WIDTH-1:0] writableCount;
    logic [1:0] headValid;
    insnEntry_t [1:0] head;
    logic pop1;
    logic pop2;

    FetchAxiReader u_reader (
        .clk, .rst, .lineReq, .lineAddr, .lineDone, .lineResp, .busy,
        .arValid, .arReady, .ar, .rValid, .rReady, .r
    );

    FetchPcStage u_pcStage (
        .clk, .rst, .redirectValid, .redirectPc, .lineReq, .lineAddr, .busy,
        .lineDone, .lineResp, .lineValid, .lineOut, .stall, .flush
    );

    InsnTraverseStage u_traverse (
        .lineValid, .line(lineOut), .writableCount, .stall,
        .writeLow, .writeHigh, .entryLow, .entryHigh
    );

    InsnBuffer u_buffer (
        .clk, .rst, .flush, .writeLow, .writeHigh, .entryLow, .entryHigh,
        .writableCount, .headValid, .head, .pop1, .pop2
    );

    InsnAligner u_aligner (
        .headValid, .head, .insnValid, .insn, .insnReady, .pop1, .pop2
    );
endmodule

// File: design/InsnAligner.sv
// Instruction aligner
`timescale 1ns/1ps

module InsnAligner import FetchTypes::*; (
    input  logic             [1:0] headValid,
    input  insnEntry_t       [1:0] head,
    output logic                   insnValid,
    output fetchedInsn_t           insn,
    input  logic                   insnReady,
    output logic                   pop1,
    output logic                   pop2
);
    logic isFull;       // low bits 11 means a 32-bit instruction
    logic fire;

    always_comb begin
        isFull = (head[0].parcel[1:0] == 2'b11);
        // a 32-bit insn waits for its second parcel
        insnValid = headValid[0] && (!isFull || headValid[1]);
        fire = insnValid && insnReady;
    end

    always_comb begin
        insn.pc = head[0].pc;                   // first parcel gives the pc
        insn.isCompressed = !isFull;
        if (isFull) begin
            insn.insn = {head[1].parcel, head[0].parcel};
            insn.fault = head[0].fault | head[1].fault;
        end else begin
            insn.insn = {16'h0000, head[0].parcel};
            insn.fault = head[0].fault;
        end
    end

    // pop as many parcels as the insn used
    assign pop1 = fire && !isFull;
    assign pop2 = fire && isFull;
endmodule

// File: design/InsnBuffer.sv
// Halfword instruction buffer
`timescale 1ns/1ps
`include "fetch_defs.svh"

module InsnBuffer import FetchTypes::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              writeLow,
    input  logic                              writeHigh,
    input  insnEntry_t                        entryLow,
    input  insnEntry_t                        entryHigh,
    output logic [`INSN_BUFFER_CNT_WIDTH-1:0] writableCount,
    output logic [1:0]                        headValid,
    output insnEntry_t [1:0]                  head,
    input  logic                              pop1,
    input  logic                              pop2
);
    localparam int DEPTH = `INSN_BUFFER_DEPTH;
    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = `INSN_BUFFER_CNT_WIDTH;

    insnEntry_t mem [DEPTH];
    logic [PTR_WIDTH-1:0] headPtr;
    logic [PTR_WIDTH-1:0] tailPtr;
    logic [PTR_WIDTH-1:0] highPtr;      // slot for the high parcel
    logic [PTR_WIDTH-1:0] secondPtr;    // entry behind the head
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] pushCount;
    logic [CNT_WIDTH-1:0] popCount;

    always_comb begin
        pushCount = CNT_WIDTH'(writeLow) + CNT_WIDTH'(writeHigh);
        popCount = pop2 ? CNT_WIDTH'(2) : CNT_WIDTH'(pop1);
        highPtr = tailPtr + PTR_WIDTH'(writeLow);   // high follows low
        secondPtr = headPtr + 1'b1;                 // wraps, depth is a power of two
    end

    // read window on the two oldest parcels
    always_comb begin
        writableCount = CNT_WIDTH'(DEPTH) - count;
        headValid[0] = (count != '0);
        headValid[1] = (count >= CNT_WIDTH'(2));
        head[0] = mem[headPtr];
        head[1] = mem[secondPtr];
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            headPtr <= headPtr + PTR_WIDTH'(popCount);
            tailPtr <= tailPtr + PTR_WIDTH'(pushCount);
            count <= count + pushCount - popCount;
        end
    end

    // parcel storage, pointers alone decide what is live
    always_ff @(posedge clk) begin
        if (writeLow)
            mem[tailPtr] <= entryLow;
        if (writeHigh)
            mem[highPtr] <= entryHigh;
    end
endmodule

// File: design/InsnTraverseStage.sv
// Line to parcel traverse stage
`timescale 1ns/1ps
`include "fetch_defs.svh"

module InsnTraverseStage import FetchTypes::*; (
    input  logic                              lineValid,
    input  lineResp_t                         line,
    input  logic [`INSN_BUFFER_CNT_WIDTH-1:0] writableCount,
    output logic                              stall,
    output logic                              writeLow,
    output logic                              writeHigh,
    output insnEntry_t                        entryLow,
    output insnEntry_t                        entryHigh
);
    localparam int ADDR_WIDTH = `FETCH_ADDR_WIDTH;
    localparam int WORD_OFF = $clog2(`FETCH_AXI_DATA_WIDTH / 8);
    localparam int WORD_IDX_WIDTH = $clog2(`FETCH_WORDS_PER_LINE);

    logic [WORD_IDX_WIDTH-1:0] wordIdx;
    fetchWord_u word;
    logic upperHalf;        // PC on the high parcel

    always_comb begin
        wordIdx = line.pc[WORD_OFF +: WORD_IDX_WIDTH];   // PC bit 2
        word.word = line.line[wordIdx];
        upperHalf = line.pc[1];
        stall = writableCount < 2;                   // room for a full word only
    end

    // low parcel skipped when entering at the upper half
    always_comb begin
        writeLow = lineValid && !stall && !upperHalf;
        writeHigh = lineValid && !stall;

        entryLow.pc = {line.pc[ADDR_WIDTH-1:2], 2'b00};
        entryLow.parcel = word.half[0];
        entryLow.fault = line.fault;

        entryHigh.pc = {line.pc[ADDR_WIDTH-1:2], 2'b10};
        entryHigh.parcel = word.half[1];
        entryHigh.fault = line.fault;
    end
endmodule

// File: design/FetchPcStage.sv
// Fetch PC and line holding stage
`timescale 1ns/1ps
`include "fetch_defs.svh"

module FetchPcStage import FetchTypes::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      redirectValid,
    input  vaddr_t    redirectPc,
    output logic      lineReq,
    output vaddr_t    lineAddr,
    input  logic      busy,
    input  logic      lineDone,
    input  lineResp_t lineResp,
    output logic      lineValid,
    output lineResp_t lineOut,
    input  logic      stall,
    output logic      flush
);
    localparam int ADDR_WIDTH = `FETCH_ADDR_WIDTH;
    localparam int LINE_OFF = $clog2(`FETCH_LINE_WIDTH / 8);

    vaddr_t pc;
    vaddr_t nextPc;
    logic epoch;            // flips on every redirect
    logic reqEpoch;         // epoch of the line in flight
    logic holdValid;
    lineResp_t holdResp;
    logic lineFresh;
    logic accept;

    assign flush = redirectValid;
    assign lineReq = !holdValid && !busy && !redirectValid;
    assign lineAddr = {pc[ADDR_WIDTH-1:LINE_OFF], {LINE_OFF{1'b0}}};
    assign lineFresh = lineDone && (reqEpoch == epoch) && !redirectValid;   // stale lines drop
    assign accept = holdValid && !stall && !redirectValid;
    assign nextPc = {pc[ADDR_WIDTH-1:2] + 1'b1, 2'b00};   // next word boundary

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            epoch <= 1'b0;
            reqEpoch <= 1'b0;
            holdValid <= 1'b0;
        end else begin
            if (redirectValid) begin
                pc <= redirectPc;
                epoch <= ~epoch;
                holdValid <= 1'b0;
            end else if (accept) begin
                pc <= nextPc;
                holdValid <= 1'b0;              // line is fetched again for the new PC
            end else if (lineFresh) begin
                holdValid <= 1'b1;
            end
            if (lineReq)
                reqEpoch <= epoch;
        end
    end

    always_ff @(posedge clk) begin
        if (lineFresh)
            holdResp <= lineResp;
    end

    // held line goes out tagged with the fetch PC
    assign lineValid = holdValid;
    assign lineOut.pc = pc;
    assign lineOut.line = holdResp.line;
    assign lineOut.fault = holdResp.fault;
endmodule

// File: design/FetchAxiReader.sv
// AXI4-Lite line read master
`timescale 1ns/1ps
`include "fetch_defs.svh"

module FetchAxiReader import FetchTypes::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      lineReq,
    input  vaddr_t    lineAddr,
    output logic      lineDone,
    output lineResp_t lineResp,
    output logic      busy,
    output logic      arValid,
    input  logic      arReady,
    output axiAr_t    ar,
    input  logic      rValid,
    output logic      rReady,
    input  axiR_t     r
);
    localparam int ADDR_WIDTH = `FETCH_ADDR_WIDTH;
    localparam int WORDS = `FETCH_WORDS_PER_LINE;
    localparam int BEAT_WIDTH = $clog2(WORDS);
    localparam int WORD_OFF = $clog2(`FETCH_AXI_DATA_WIDTH / 8);
    localparam int LINE_OFF = $clog2(`FETCH_LINE_WIDTH / 8);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, DONE} readState_e;

    readState_e state;
    logic [BEAT_WIDTH-1:0] beat;                    // word being read
    logic [ADDR_WIDTH-1:LINE_OFF] lineTag;          // latched line address
    fetchLine_t lineData;
    logic lineFault;

    // one word at a time, AR then R
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beat <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (lineReq) begin
                        state <= ADDR;
                        beat <= '0;
                    end
                end
                ADDR: begin
                    if (arReady)
                        state <= DATA;
                end
                DATA: begin
                    if (rValid) begin
                        if (beat == BEAT_WIDTH'(WORDS - 1)) begin
                            state <= DONE;      // last beat in
                        end else begin
                            beat <= beat + 1'b1;
                            state <= ADDR;
                        end
                    end
                end
                default: state <= IDLE;         // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && lineReq) begin
            lineTag <= lineAddr[ADDR_WIDTH-1:LINE_OFF];
            lineFault <= 1'b0;
        end
        if (state == DATA && rValid) begin
            lineData[beat] <= r.data;
            lineFault <= lineFault | r.resp[1];   // SLVERR or DECERR
        end
    end

    assign busy = (state != IDLE);
    assign arValid = (state == ADDR);
    assign rReady = (state == DATA);
    assign lineDone = (state == DONE);

    assign ar.addr = {lineTag, beat, {WORD_OFF{1'b0}}};
    assign ar.prot = 3'b100;                        // instruction, unprivileged

    assign lineResp.pc = {lineTag, {LINE_OFF{1'b0}}};
    assign lineResp.line = lineData;
    assign lineResp.fault = lineFault;
endmodule

// File: design/FetchTypes.sv
// Fetch unit types
`include "fetch_defs.svh"

package FetchTypes;

    typedef logic [`FETCH_ADDR_WIDTH-1:0] vaddr_t;   // byte address
    typedef logic [15:0] parcel_t;                    // one RVC-sized half

    // line as an array of AXI words, word 0 at the lower address
    typedef logic [`FETCH_WORDS_PER_LINE-1:0][`FETCH_AXI_DATA_WIDTH-1:0] fetchLine_t;

    // 32-bit word seen whole or as low/high parcels
    typedef union packed {
        logic [31:0]         word;
        parcel_t [1:0]       half;   // half[0] is the low parcel
    } fetchWord_u;

    typedef struct packed {
        vaddr_t  pc;        // address of this parcel
        parcel_t parcel;
        logic    fault;     // AXI error on its word
    } insnEntry_t;

    typedef struct packed {
        vaddr_t     pc;     // line address from reader, fetch PC after PC stage
        fetchLine_t line;
        logic       fault;
    } lineResp_t;

    typedef struct packed {
        vaddr_t      pc;
        logic [31:0] insn;          // upper half zero when compressed
        logic        isCompressed;
        logic        fault;
    } fetchedInsn_t;

    // AR channel payload
    typedef struct packed {
        vaddr_t     addr;
        logic [2:0] prot;
    } axiAr_t;

    // R channel payload
    typedef struct packed {
        logic [`FETCH_AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                       resp;
    } axiR_t;

endpackage

// File: include/fetch_defs.svh
// Fetch unit parameters
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// virtual byte address
`define FETCH_ADDR_WIDTH 32

// one fetched line, two AXI words
`define FETCH_LINE_WIDTH 64

// memory-side read data
`define FETCH_AXI_DATA_WIDTH 32

// halfword parcels held, keep a power of two
`define INSN_BUFFER_DEPTH 8

// derived values
`define FETCH_WORDS_PER_LINE (`FETCH_LINE_WIDTH / `FETCH_AXI_DATA_WIDTH)
`define INSN_BUFFER_CNT_WIDTH ($clog2(`INSN_BUFFER_DEPTH + 1))

`endif
